// ==== design/ifetch_pkg.sv ====
package ifetch_pkg;

  // bus word and program counter
  localparam int WORD_W = 32;
  localparam int IR_W   = 64;

  // one read per word, consecutive addresses
  localparam int BURST_LEN = 4;

  localparam int QUEUE_DEPTH = 16;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int CNT_W       = 5;          // holds 0..QUEUE_DEPTH

  localparam logic [WORD_W-1:0] RESET_PC  = '0;
  localparam logic [WORD_W-1:0] WORD_STEP = 4;    // byte stride of one word

  // last request index of a burst
  localparam logic [CNT_W-1:0] BURST_LAST = CNT_W'(BURST_LEN - 1);

  // highest fill level that still leaves room for a whole burst
  localparam logic [CNT_W-1:0] FILL_MAX = CNT_W'(QUEUE_DEPTH - BURST_LEN);

  // program memory
  localparam int ROM_WORDS = 256;
  localparam int ROM_AW    = 8;

endpackage

// ==== design/word_queue.sv ====
`timescale 1ns/1ps

module word_queue
  (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          flush_i,
  input  logic                          push_i,
  input  logic [ifetch_pkg::WORD_W-1:0] push_dat_i,
  input  logic                          pop_i,
  output logic [ifetch_pkg::WORD_W-1:0] head_o,
  output logic                          empty_o,
  output logic [ifetch_pkg::CNT_W-1:0]  count_o
  );

  logic [ifetch_pkg::WORD_W-1:0] mem [ifetch_pkg::QUEUE_DEPTH];
  logic [ifetch_pkg::QPTR_W-1:0] rd_ptr;
  logic [ifetch_pkg::QPTR_W-1:0] wr_ptr;
  logic [ifetch_pkg::CNT_W-1:0]  count;
  logic                          do_pop;

  assign do_pop  = pop_i && (count != '0);    // ignore pops on empty
  assign head_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign count_o = count;

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      mem[wr_ptr] <= push_dat_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else if (flush_i)
    begin
      // drops whatever arrives in this cycle too
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
      begin
        wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/fetch_bus.sv ====
`timescale 1ns/1ps

module fetch_bus
  (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          redirect_i,
  input  logic [ifetch_pkg::WORD_W-1:0] target_i,
  input  logic                          halt_i,
  input  logic [ifetch_pkg::CNT_W-1:0]  fill_i,
  output logic                          bus_cyc_o,
  output logic                          bus_stb_o,
  output logic [ifetch_pkg::WORD_W-1:0] bus_adr_o,
  input  logic                          bus_stall_i,
  input  logic                          bus_ack_i
  );

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_DRAIN, S_HALT} state_t;

  state_t                        state_q;
  state_t                        state_d;
  logic [ifetch_pkg::CNT_W-1:0]  req_q;
  logic [ifetch_pkg::CNT_W-1:0]  req_d;
  logic [ifetch_pkg::CNT_W-1:0]  ack_q;
  logic [ifetch_pkg::CNT_W-1:0]  ack_d;
  logic [ifetch_pkg::WORD_W-1:0] adr_q;
  logic [ifetch_pkg::WORD_W-1:0] adr_d;
  logic                          accept;
  logic                          room;

  assign accept = bus_stb_o && !bus_stall_i;
  assign room   = (fill_i <= ifetch_pkg::FILL_MAX);    // a full burst fits

  assign bus_cyc_o = (state_q == S_REQ) || (state_q == S_DRAIN);
  // no request in a redirect cycle, its ack would land after the flush
  assign bus_stb_o = (state_q == S_REQ) && !redirect_i;
  assign bus_adr_o = adr_q;

  always_comb
  begin
    state_d = state_q;
    req_d   = req_q;
    adr_d   = adr_q;
    ack_d   = bus_ack_i ? ack_q + 1'b1 : ack_q;

    case (state_q)
      S_IDLE:
      begin
        req_d = '0;
        ack_d = '0;
        if (halt_i)
        begin
          state_d = S_HALT;    // between bursts, safe to stop
        end
        else if (room)
        begin
          state_d = S_REQ;
        end
      end
      S_REQ:
      begin
        if (accept)
        begin
          adr_d = adr_q + ifetch_pkg::WORD_STEP;
          req_d = req_q + 1'b1;
          if (req_q == ifetch_pkg::BURST_LAST)
          begin
            state_d = S_DRAIN;
          end
        end
      end
      S_DRAIN:
      begin
        // counts this cycle's ack as well
        if (ack_d == req_q)
        begin
          state_d = halt_i ? S_HALT : S_IDLE;
        end
      end
      default:
      begin
        state_d = S_HALT;    // stays here until reset
      end
    endcase

    if (redirect_i && (state_q != S_HALT))
    begin
      adr_d   = target_i;
      req_d   = '0;
      ack_d   = '0;    // outstanding acks are abandoned
      state_d = S_IDLE;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_IDLE;
      req_q   <= '0;
      ack_q   <= '0;
      adr_q   <= ifetch_pkg::RESET_PC;
    end
    else
    begin
      state_q <= state_d;
      req_q   <= req_d;
      ack_q   <= ack_d;
      adr_q   <= adr_d;
    end
  end

endmodule

// ==== design/insn_align.sv ====
`timescale 1ns/1ps

module insn_align
  (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          redirect_i,
  input  logic [ifetch_pkg::WORD_W-1:0] target_i,
  input  logic                          stall_i,
  input  logic                          empty_i,
  input  logic [ifetch_pkg::WORD_W-1:0] head_i,
  output logic                          pop_o,
  output logic [ifetch_pkg::IR_W-1:0]   ir_o,
  output logic [ifetch_pkg::WORD_W-1:0] pc_o
  );

  typedef enum logic [1:0] {S_RESTART, S_FIRST, S_SECOND} state_t;

  state_t                        state_q;
  logic [ifetch_pkg::WORD_W-1:0] low_q;    // low half of a long insn
  logic                          take;

  assign take  = (state_q != S_RESTART) && !empty_i && !stall_i && !redirect_i;
  assign pop_o = take;

  always_ff @(posedge clk_i)
  begin
    if (take && (state_q == S_FIRST))
    begin
      low_q <= head_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_RESTART;
      ir_o    <= '0;
      pc_o    <= ifetch_pkg::RESET_PC;
    end
    else if (redirect_i)
    begin
      state_q <= S_RESTART;
      ir_o    <= '0;
      pc_o    <= target_i;
    end
    else if (!stall_i)
    begin
      ir_o <= '0;    // bubble unless a new insn completes
      case (state_q)
        S_RESTART:
        begin
          state_q <= S_FIRST;
        end
        S_FIRST:
        begin
          if (!empty_i)
          begin
            pc_o <= pc_o + ifetch_pkg::WORD_STEP;
            if (head_i[0])
            begin
              state_q <= S_SECOND;    // wait for the high word
            end
            else
            begin
              ir_o <= {{(ifetch_pkg::IR_W - ifetch_pkg::WORD_W){1'b0}}, head_i};
            end
          end
        end
        S_SECOND:
        begin
          if (!empty_i)
          begin
            pc_o    <= pc_o + ifetch_pkg::WORD_STEP;
            ir_o    <= {head_i, low_q};
            state_q <= S_FIRST;
          end
        end
        default:
        begin
          state_q <= S_RESTART;
        end
      endcase
    end
  end

endmodule

// ==== design/prog_rom.sv ====
`timescale 1ns/1ps

module prog_rom
  (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          prog_we_i,
  input  logic [ifetch_pkg::ROM_AW-1:0] prog_adr_i,
  input  logic [ifetch_pkg::WORD_W-1:0] prog_dat_i,
  input  logic                          bus_stb_i,
  input  logic [ifetch_pkg::WORD_W-1:0] bus_adr_i,
  output logic                          bus_stall_o,
  output logic                          bus_ack_o,
  output logic [ifetch_pkg::WORD_W-1:0] bus_dat_o
  );

  logic [ifetch_pkg::WORD_W-1:0] mem [ifetch_pkg::ROM_WORDS];
  logic [ifetch_pkg::ROM_AW-1:0] rd_idx;
  logic                          accept;

  // byte offset dropped, upper bits wrap
  assign rd_idx = bus_adr_i[ifetch_pkg::ROM_AW+1:2];

  // loader owns the array while it writes
  assign bus_stall_o = prog_we_i;
  assign accept      = bus_stb_i && !prog_we_i;

  always_ff @(posedge clk_i)
  begin
    if (prog_we_i)
    begin
      mem[prog_adr_i] <= prog_dat_i;
    end
    if (accept)
    begin
      bus_dat_o <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      bus_ack_o <= 1'b0;
    end
    else
    begin
      bus_ack_o <= accept;    // one cycle after acceptance
    end
  end

endmodule

// ==== design/ifetch_top.sv ====
`timescale 1ns/1ps

module ifetch_top
  (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          redirect_i,
  input  logic [ifetch_pkg::WORD_W-1:0] target_i,
  input  logic                          halt_i,
  input  logic                          stall_i,
  input  logic                          prog_we_i,
  input  logic [ifetch_pkg::ROM_AW-1:0] prog_adr_i,
  input  logic [ifetch_pkg::WORD_W-1:0] prog_dat_i,
  output logic [ifetch_pkg::IR_W-1:0]   ir_o,
  output logic [ifetch_pkg::WORD_W-1:0] pc_o,
  output logic                          bus_cyc_o
  );

  logic                          bus_stb;
  logic [ifetch_pkg::WORD_W-1:0] bus_adr;
  logic                          bus_stall;
  logic                          bus_ack;
  logic [ifetch_pkg::WORD_W-1:0] bus_dat;

  logic                          q_empty;
  logic [ifetch_pkg::WORD_W-1:0] q_head;
  logic [ifetch_pkg::CNT_W-1:0]  q_count;
  logic                          q_pop;

  fetch_bus u_bus (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .redirect_i  (redirect_i),
    .target_i    (target_i),
    .halt_i      (halt_i),
    .fill_i      (q_count),
    .bus_cyc_o   (bus_cyc_o),
    .bus_stb_o   (bus_stb),
    .bus_adr_o   (bus_adr),
    .bus_stall_i (bus_stall),
    .bus_ack_i   (bus_ack)
  );

  prog_rom u_rom (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .prog_we_i   (prog_we_i),
    .prog_adr_i  (prog_adr_i),
    .prog_dat_i  (prog_dat_i),
    .bus_stb_i   (bus_stb),
    .bus_adr_i   (bus_adr),
    .bus_stall_o (bus_stall),
    .bus_ack_o   (bus_ack),
    .bus_dat_o   (bus_dat)
  );

  // every ack lands in the queue
  word_queue u_queue (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (redirect_i),
    .push_i     (bus_ack),
    .push_dat_i (bus_dat),
    .pop_i      (q_pop),
    .head_o     (q_head),
    .empty_o    (q_empty),
    .count_o    (q_count)
  );

  insn_align u_align (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .redirect_i (redirect_i),
    .target_i   (target_i),
    .stall_i    (stall_i),
    .empty_i    (q_empty),
    .head_i     (q_head),
    .pop_o      (q_pop),
    .ir_o       (ir_o),
    .pc_o       (pc_o)
  );

endmodule

// ==== verif/ifetch_sva.sv ====
`timescale 1ns/1ps

module ifetch_sva
  (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          bus_cyc_i,
  input logic                          bus_stb_i,
  input logic [ifetch_pkg::WORD_W-1:0] bus_adr_i,
  input logic                          bus_stall_i,
  input logic                          halted_i
  );

  int fails = 0;

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_stb_i |-> bus_cyc_i)
    else
    begin
      $error("strobe outside a bus cycle");
      fails++;
    end

  a_adr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (bus_stb_i && bus_stall_i) |=> $stable(bus_adr_i))
    else
    begin
      $error("address moved under stall");
      fails++;
    end

  // halted requester stays off the bus
  a_halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    halted_i |-> (!bus_stb_i && !bus_cyc_i))
    else
    begin
      $error("bus activity after halt");
      fails++;
    end

endmodule

// ==== verif/ifetch_tb.sv ====
`timescale 1ns/1ps

module ifetch_tb;

  localparam int N_SHORT = 24;
  localparam int N_MIXED = 40;
  localparam int N_STALL = 40;
  localparam int N_REDIR = 20;
  localparam int N_LOAD  = 24;
  localparam int N_HALT  = 40;
  // two words per insn at worst and eight cycles per word
  localparam int CYCLE_LIMIT = 16 * (N_SHORT + N_MIXED + N_STALL + N_REDIR + N_LOAD + N_HALT)
    + ifetch_pkg::ROM_WORDS + 50 * ifetch_pkg::BURST_LEN;

  logic                          clk;
  logic                          rst;
  logic                          redirect;
  logic                          halt;
  logic                          stall;
  logic                          prog_we;
  logic                          bus_cyc;
  logic [ifetch_pkg::WORD_W-1:0] target;
  logic [ifetch_pkg::ROM_AW-1:0] prog_adr;
  logic [ifetch_pkg::WORD_W-1:0] prog_dat;
  logic [ifetch_pkg::IR_W-1:0]   ir;
  logic [ifetch_pkg::WORD_W-1:0] pc;

  logic [ifetch_pkg::WORD_W-1:0] prog [ifetch_pkg::ROM_WORDS];    // copy of the loaded program
  logic [ifetch_pkg::IR_W-1:0]   exp_ir [$];
  logic [ifetch_pkg::WORD_W-1:0] exp_pc [$];
  logic [ifetch_pkg::IR_W-1:0]   ir_last;
  logic [ifetch_pkg::WORD_W-1:0] pc_last;
  bit                            held;
  int                            errors;
  int                            checks;
  int                            n_seen;
  int                            cycles;
  integer                        seed;

  ifetch_top dut0 (
    .clk_i      (clk),
    .rst_i      (rst),
    .redirect_i (redirect),
    .target_i   (target),
    .halt_i     (halt),
    .stall_i    (stall),
    .prog_we_i  (prog_we),
    .prog_adr_i (prog_adr),
    .prog_dat_i (prog_dat),
    .ir_o       (ir),
    .pc_o       (pc),
    .bus_cyc_o  (bus_cyc)
  );

  bind fetch_bus ifetch_sva sva0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_cyc_i   (bus_cyc_o),
    .bus_stb_i   (bus_stb_o),
    .bus_adr_i   (bus_adr_o),
    .bus_stall_i (bus_stall_i),
    .halted_i    (state_q == S_HALT)
  );

  always #20 clk = ~clk;

  task automatic compare_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // expected insns and pc after each from the program copy
  function automatic logic [31:0] build_expected(input logic [31:0] start_pc, input int n);
    logic [31:0] wpc;
    logic [31:0] lo;
    int          k;
    wpc = start_pc;
    for (k = 0; k < n; k++)
    begin
      lo  = prog[wpc[ifetch_pkg::ROM_AW+1:2]];
      wpc = wpc + 4;
      if (lo[0])
      begin
        exp_ir.push_back({prog[wpc[ifetch_pkg::ROM_AW+1:2]], lo});    // high over low
        wpc = wpc + 4;
      end
      else
      begin
        exp_ir.push_back({32'b0, lo});
      end
      exp_pc.push_back(wpc);
    end
    return wpc;
  endfunction

  task automatic load_program();
    logic [31:0] w;
    int          pick;
    int          i;
    for (i = 0; i < ifetch_pkg::ROM_WORDS; i++)
    begin
      w    = $random(seed);
      pick = $random(seed);
      w[0] = (i >= N_SHORT) && ((pick % 3) == 0);    // short-only head
      if (w == '0)
      begin
        w = 32'h0000_0100;
      end
      prog[i]  = w;
      prog_we  = 1'b1;
      prog_adr = i[ifetch_pkg::ROM_AW-1:0];
      prog_dat = w;
      @(negedge clk);
    end
    prog_we = 1'b0;
  endtask

  task automatic wait_insns(input int n);
    int goal;
    goal = n_seen + n;
    while (n_seen < goal)
      @(negedge clk);
  endtask

  task automatic report_test(input int num, input string name, input int mark);
    $display("test %0d %s: %0d errors", num, name, errors - mark);
  endtask

  // outputs read before this edge's update
  always @(posedge clk)
  begin
    if (!rst && held)
    begin
      compare_value("ir_o under stall", ir, ir_last);
      compare_value("pc_o under stall", 64'(pc), 64'(pc_last));
    end
    else if (!rst && (ir != '0))
    begin
      if (exp_ir.size() == 0)
      begin
        errors++;
        $display("error at %0t ns: instruction %h arrived with none expected", $time, ir);
      end
      else
      begin
        compare_value("instruction", ir, exp_ir.pop_front());
        compare_value("pc after instruction", 64'(pc), 64'(exp_pc.pop_front()));
        n_seen++;
      end
    end
    held    = stall && !rst;
    ir_last = ir;
    pc_last = pc;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  initial
  begin
    logic [31:0]                   next_pc;
    logic [ifetch_pkg::ROM_AW-1:0] ld_adr;
    logic [31:0]                   ld_dat;
    int                            mark;
    int                            goal;
    int                            k;
    int                            seen_halt;
    int                            total;
    clk      = 1'b0;
    rst      = 1'b1;
    redirect = 1'b0;
    halt     = 1'b0;
    stall    = 1'b0;
    prog_we  = 1'b0;
    target   = '0;
    prog_adr = '0;
    prog_dat = '0;
    seed     = 32'h645a_076f;
    repeat (5) @(negedge clk);
    load_program();

    mark = errors;
    compare_value("bus_cyc_o in reset", 64'(bus_cyc), 64'd0);
    compare_value("ir_o in reset", ir, 64'd0);
    compare_value("pc_o in reset", 64'(pc), 64'(ifetch_pkg::RESET_PC));
    next_pc = build_expected(ifetch_pkg::RESET_PC, N_SHORT);
    rst = 1'b0;
    wait_insns(N_SHORT);
    report_test(1, "short stream", mark);

    mark = errors;
    next_pc = build_expected(next_pc, N_MIXED);
    wait_insns(N_MIXED);
    report_test(2, "mixed stream", mark);

    mark = errors;
    next_pc = build_expected(next_pc, N_STALL);
    goal = n_seen + N_STALL;
    while (n_seen < goal)
    begin
      stall = (($random(seed) % 3) == 0);
      @(negedge clk);
    end
    stall = 1'b0;
    report_test(3, "random stall", mark);

    mark = errors;
    // an old insn may still show on the edge that takes the redirect
    next_pc = build_expected(next_pc, 1);
    redirect = 1'b1;
    target   = 32'h0000_0300;
    @(negedge clk);
    redirect = 1'b0;
    exp_ir.delete();
    exp_pc.delete();
    next_pc = build_expected(target, N_REDIR);
    wait_insns(N_REDIR);
    report_test(4, "redirect", mark);

    mark = errors;
    next_pc = build_expected(next_pc, N_LOAD);
    ld_adr = 8'h40;    // well clear of the fetched words
    goal = n_seen + N_LOAD;
    while (n_seen < goal)
    begin
      prog_we = (($random(seed) % 2) == 0);
      if (prog_we)
      begin
        ld_dat       = $random(seed) | 32'h100;
        prog_adr     = ld_adr;
        prog_dat     = ld_dat;
        prog[ld_adr] = ld_dat;
        ld_adr[5:0]  = ld_adr[5:0] + 1'b1;
      end
      @(negedge clk);
    end
    prog_we = 1'b0;
    report_test(5, "loader back-pressure", mark);

    mark = errors;
    next_pc = build_expected(next_pc, N_HALT);
    halt = 1'b1;
    k = 0;
    while (bus_cyc && (k < 2 * ifetch_pkg::BURST_LEN))
    begin
      @(negedge clk);
      k++;
    end
    compare_value("bus_cyc_o low within a burst", 64'(bus_cyc), 64'd0);
    repeat (40)
    begin
      @(negedge clk);
      compare_value("bus_cyc_o after halt", 64'(bus_cyc), 64'd0);
    end
    seen_halt = n_seen;
    repeat (20) @(negedge clk);
    compare_value("instructions after drain", 64'(n_seen), 64'(seen_halt));
    report_test(6, "halt", mark);

    total = errors + dut0.u_bus.sva0.fails;
    $display("tests: 6, checks: %0d, errors: %0d", checks, total);
    if (total == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== ifetch.f ====
design/ifetch_pkg.sv
design/word_queue.sv
design/fetch_bus.sv
design/insn_align.sv
design/prog_rom.sv
design/ifetch_top.sv
verif/ifetch_sva.sv
verif/ifetch_tb.sv

// ==== Makefile ====
TOP = ifetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ifetch.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
